//--- list.f
+incdir+source
source/rv_decoder_pkg.sv
source/rv_op_decode.sv
source/rv_imm_gen.sv
source/rv_decode_reg.sv
source/rv_decoder.sv
verif/tb_rv_decoder.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_rv_decoder -Mdir obj_dir -f list.f

out=$(./obj_dir/Vtb_rv_decoder)
echo "$out"

if echo "$out" | grep -qx "Test completed successfully"; then
   exit 0
fi
exit 1

//--- verif/tb_rv_decoder.sv
`include "rv_decoder_defs.svh"

module tb_rv_decoder;

   timeunit 1ns;
   timeprecision 1ps;

   import rv_decoder_pkg::*;

   typedef struct packed {
      rv_op_e                op;
      logic [`RV_REG_W-1:0]  rd;
      logic [`RV_REG_W-1:0]  rs1;
      logic [`RV_REG_W-1:0]  rs2;
      logic [`RV_XLEN-1:0]   imm;
      logic [`RV_XLEN-1:0]   pc;
      // load, store, branch, writes_reg, legal
      logic [4:0]            flags;
   } exp_rec_t;

   logic                  clk;
   logic                  rstn;
   logic                  in_valid;
   logic                  in_ready;
   logic [`RV_XLEN-1:0]   in_instr;
   logic [`RV_XLEN-1:0]   in_pc;
   logic [`RV_REG_W-1:0]  rf_rs1;
   logic [`RV_REG_W-1:0]  rf_rs2;
   logic                  out_valid;
   logic                  out_ready;
   rv_op_e                out_op;
   logic [`RV_REG_W-1:0]  out_rd;
   logic [`RV_REG_W-1:0]  out_rs1;
   logic [`RV_REG_W-1:0]  out_rs2;
   logic [`RV_XLEN-1:0]   out_imm;
   logic [`RV_XLEN-1:0]   out_pc;
   logic                  out_is_load;
   logic                  out_is_store;
   logic                  out_is_branch;
   logic                  out_writes_reg;
   logic                  out_legal;
   logic [4:0]            out_flags;

   exp_rec_t  sb_q[$];
   exp_rec_t  head;
   int        pending = 0;
   int        error_count = 0;
   int        accepted = 0;
   int        delivered = 0;
   logic [31:0] rng = 32'h484d_7fba;

   // operation tables indexed by funct3
   rv_op_e branch_tbl [8] = '{OP_BEQ, OP_BNE, OP_ILLEGAL, OP_ILLEGAL,
                              OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
   rv_op_e load_tbl [8] = '{OP_LB, OP_LH, OP_LW, OP_ILLEGAL,
                            OP_LBU, OP_LHU, OP_ILLEGAL, OP_ILLEGAL};
   rv_op_e store_tbl [8] = '{OP_SB, OP_SH, OP_SW, OP_ILLEGAL,
                             OP_ILLEGAL, OP_ILLEGAL, OP_ILLEGAL, OP_ILLEGAL};
   rv_op_e imm_tbl [8] = '{OP_ADDI, OP_ILLEGAL, OP_SLTI, OP_SLTIU,
                           OP_XORI, OP_ILLEGAL, OP_ORI, OP_ANDI};
   rv_op_e reg_tbl [8] = '{OP_ADD, OP_SLL, OP_SLT, OP_SLTU,
                           OP_XOR, OP_SRL, OP_OR, OP_AND};
   rv_op_e mul_tbl [8] = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
                           OP_DIV, OP_DIVU, OP_REM, OP_REMU};
   rv_opcode_e opc_tbl [11] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                                OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP,
                                OPC_MISC_MEM, OPC_SYSTEM};

   assign out_flags = {out_is_load, out_is_store, out_is_branch, out_writes_reg, out_legal};

   rv_decoder dut0 (.*);

   always #4 clk = ~clk;

   function automatic logic [31:0] next_rand();
      rng = rng * 32'd1664525 + 32'd1013904223;
      return rng;
   endfunction

   function automatic rv_op_e ref_op(input logic [31:0] w);
      logic [2:0] f3;
      logic [6:0] f7;
      logic       no_regs;
      f3 = w[14:12];
      f7 = w[31:25];
      no_regs = (w[11:7] == 5'd0) && (w[19:15] == 5'd0);
      case (w[6:0])
         OPC_LUI:    return OP_LUI;
         OPC_AUIPC:  return OP_AUIPC;
         OPC_JAL:    return OP_JAL;
         OPC_JALR:   return (f3 == 3'd0) ? OP_JALR : OP_ILLEGAL;
         OPC_BRANCH: return branch_tbl[f3];
         OPC_LOAD:   return load_tbl[f3];
         OPC_STORE:  return store_tbl[f3];
         OPC_OP_IMM: begin
            if (f3 == 3'd1) return (f7 == `RV_F7_BASE) ? OP_SLLI : OP_ILLEGAL;
            if (f3 == 3'd5) begin
               if (f7 == `RV_F7_BASE) return OP_SRLI;
               return (f7 == `RV_F7_ALT) ? OP_SRAI : OP_ILLEGAL;
            end
            return imm_tbl[f3];
         end
         OPC_OP: begin
            if (f7 == `RV_F7_BASE) return reg_tbl[f3];
            if (f7 == `RV_F7_MULDIV) return mul_tbl[f3];
            if (f7 == `RV_F7_ALT && f3 == 3'd0) return OP_SUB;
            if (f7 == `RV_F7_ALT && f3 == 3'd5) return OP_SRA;
            return OP_ILLEGAL;
         end
         OPC_MISC_MEM: begin
            if (no_regs && f3 == 3'd0) return OP_FENCE;
            return (no_regs && f3 == 3'd1) ? OP_FENCE_I : OP_ILLEGAL;
         end
         OPC_SYSTEM: begin
            if (!no_regs || f3 != 3'd0) return OP_ILLEGAL;
            if (w[31:20] == 12'h000) return OP_ECALL;
            return (w[31:20] == 12'h001) ? OP_EBREAK : OP_ILLEGAL;
         end
         default: return OP_ILLEGAL;
      endcase
   endfunction

   function automatic rv_fmt_e ref_fmt(input logic [31:0] w, input rv_op_e op);
      if (op == OP_ILLEGAL) return FMT_NONE;
      case (w[6:0])
         OPC_LUI, OPC_AUIPC: return FMT_U;
         OPC_JAL:            return FMT_J;
         OPC_BRANCH:         return FMT_B;
         OPC_STORE:          return FMT_S;
         OPC_OP:             return FMT_R;
         default:            return FMT_I;
      endcase
   endfunction

   function automatic logic [31:0] ref_imm(input logic [31:0] w, input rv_fmt_e fmt);
      case (fmt)
         FMT_I:   return 32'($signed(w[31:20]));
         FMT_S:   return 32'($signed({w[31:25], w[11:7]}));
         FMT_B:   return 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
         FMT_U:   return {w[31:12], 12'h000};
         FMT_J:   return 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
         default: return 32'h0;
      endcase
   endfunction

   function automatic exp_rec_t expected_record(input logic [31:0] w, input logic [31:0] pc);
      exp_rec_t rec;
      rv_op_e   op;
      rv_fmt_e  fmt;
      logic     ld;
      logic     st;
      logic     br;
      logic     ok;
      logic     wr;
      op = ref_op(w);
      fmt = ref_fmt(w, op);
      ld = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
      st = op inside {OP_SB, OP_SH, OP_SW};
      br = op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
      ok = (op != OP_ILLEGAL);
      wr = ok && !st && !br && !(op inside {OP_FENCE, OP_FENCE_I, OP_ECALL, OP_EBREAK});
      rec.op = op;
      rec.rd = (fmt inside {FMT_R, FMT_I, FMT_U, FMT_J}) ? w[11:7] : 5'd0;
      rec.rs1 = (fmt inside {FMT_R, FMT_I, FMT_S, FMT_B}) ? w[19:15] : 5'd0;
      rec.rs2 = (fmt inside {FMT_R, FMT_S, FMT_B}) ? w[24:20] : 5'd0;
      rec.imm = ref_imm(w, fmt);
      rec.pc = pc;
      rec.flags = {ld, st, br, wr, ok};
      return rec;
   endfunction

   // random fields on a legal opcode, fixed system words, or a broken opcode
   function automatic logic [31:0] make_word();
      logic [31:0] r;
      logic [31:0] w;
      int          idx;
      r = next_rand();
      w = next_rand();
      idx = int'((next_rand() >> 8) % 32'd11);
      if (r[31:28] < 4'd11) begin
         w[6:0] = opc_tbl[idx];
         if (r[27:26] == 2'd0) w[31:25] = `RV_F7_BASE;
         else if (r[27:26] == 2'd1) w[31:25] = `RV_F7_ALT;
         else if (r[27:26] == 2'd2) w[31:25] = `RV_F7_MULDIV;
      end else if (r[31:28] == 4'd11) begin
         w = {w[31:20], 5'd0, 3'b000, 5'd0, 7'b0001111};
      end else if (r[31:28] == 4'd12) begin
         w = {w[31:20], 5'd0, 3'b001, 5'd0, 7'b0001111};
      end else if (r[31:28] == 4'd13) begin
         w = 32'h0000_0073;
      end else if (r[31:28] == 4'd14) begin
         w = 32'h0010_0073;
      end else begin
         w[1:0] = 2'b10;
      end
      return w;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                  input logic [31:0] act_val);
      error_count++;
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp_val, act_val);
   endtask

   task automatic report_failure(input string what);
      error_count++;
      $display("ERROR at %0t: %s", $time, what);
   endtask

   always @(posedge clk) begin : scoreboard
      if (rstn) begin
         sb_q.delete();
      end else begin
         if (out_valid && out_ready) begin
            if (sb_q.size() == 0) begin
               report_failure("record delivered while nothing was accepted");
            end else begin
               sb_q.delete(0);
               delivered++;
            end
         end
         if (in_valid && in_ready) begin
            sb_q.push_back(expected_record(in_instr, in_pc));
            accepted++;
         end
      end
      if (sb_q.size() != 0) head <= sb_q[0];
      pending <= sb_q.size();
   end

   a_op: assert property (@(posedge clk) disable iff (rstn) out_valid |-> out_op == head.op)
      else report_mismatch("out_op", 32'($sampled(head.op)), 32'($sampled(out_op)));
   a_rd: assert property (@(posedge clk) disable iff (rstn) out_valid |-> out_rd == head.rd)
      else report_mismatch("out_rd", 32'($sampled(head.rd)), 32'($sampled(out_rd)));
   a_rs1: assert property (@(posedge clk) disable iff (rstn) out_valid |-> out_rs1 == head.rs1)
      else report_mismatch("out_rs1", 32'($sampled(head.rs1)), 32'($sampled(out_rs1)));
   a_rs2: assert property (@(posedge clk) disable iff (rstn) out_valid |-> out_rs2 == head.rs2)
      else report_mismatch("out_rs2", 32'($sampled(head.rs2)), 32'($sampled(out_rs2)));
   a_imm: assert property (@(posedge clk) disable iff (rstn) out_valid |-> out_imm == head.imm)
      else report_mismatch("out_imm", $sampled(head.imm), $sampled(out_imm));
   a_pc: assert property (@(posedge clk) disable iff (rstn) out_valid |-> out_pc == head.pc)
      else report_mismatch("out_pc", $sampled(head.pc), $sampled(out_pc));
   a_flags: assert property (@(posedge clk) disable iff (rstn)
      out_valid |-> out_flags == head.flags)
      else report_mismatch("out_flags(load,store,branch,wreg,legal)",
                           32'($sampled(head.flags)), 32'($sampled(out_flags)));

   // one-entry stage holds exactly one record while valid
   a_count: assert property (@(posedge clk) disable iff (rstn) pending == int'(out_valid))
      else report_failure("output valid does not match the number of pending records");
   a_latency: assert property (@(posedge clk) disable iff (rstn)
      in_valid && in_ready |=> out_valid && out_pc == $past(in_pc))
      else report_failure("accepted word did not appear one cycle later");
   a_stall_ready: assert property (@(posedge clk) disable iff (rstn)
      out_valid && !out_ready |-> !in_ready)
      else report_failure("in_ready high while the output is stalled");
   // empty or draining slot takes a new word
   a_free_ready: assert property (@(posedge clk) disable iff (rstn)
      !out_valid || out_ready |-> in_ready)
      else report_failure("in_ready low while the output slot is free or draining");
   a_stall_hold: assert property (@(posedge clk) disable iff (rstn)
      out_valid && !out_ready |=> out_valid &&
         $stable({out_op, out_rd, out_rs1, out_rs2, out_imm, out_pc, out_flags}))
      else report_failure("stalled record changed or vanished");
   a_reset_empty: assert property (@(posedge clk) rstn |=> !out_valid)
      else report_failure("out_valid high right after reset");
   a_rf_rs1: assert property (@(posedge clk) rf_rs1 == in_instr[19:15])
      else report_mismatch("rf_rs1", 32'($sampled(in_instr[19:15])), 32'($sampled(rf_rs1)));
   a_rf_rs2: assert property (@(posedge clk) rf_rs2 == in_instr[24:20])
      else report_mismatch("rf_rs2", 32'($sampled(in_instr[24:20])), 32'($sampled(rf_rs2)));

   initial begin : stimulus
      logic [31:0] r;
      logic [31:0] pc_next;
      int          cycles;
      clk = 1'b0;
      rstn = 1'b1;
      in_valid = 1'b0;
      in_instr = 32'h0;
      in_pc = 32'h0;
      out_ready = 1'b0;
      pc_next = 32'h0000_1000;
      repeat (5) @(posedge clk);
      rstn <= 1'b0;
      // first stretch with the consumer always ready
      for (int n = 0; n < 3000; n++) begin
         @(posedge clk);
         r = next_rand();
         if (!in_valid || in_ready) begin
            in_valid <= (r[31:30] != 2'b00);
            in_instr <= make_word();
            in_pc <= pc_next;
            pc_next = pc_next + 32'd4;
         end
         out_ready <= (n < 300) ? 1'b1 : r[29];
      end
      cycles = 0;
      do begin
         @(posedge clk);
         out_ready <= 1'b1;
         if (!in_valid || in_ready) in_valid <= 1'b0;
         cycles++;
      end while ((in_valid || out_valid) && cycles < 50);
      if (in_valid || out_valid) begin
         report_failure("timed out waiting for the decoder to drain");
      end else begin
         repeat (2) @(posedge clk);
         if (sb_q.size() != 0) report_failure("accepted records never delivered");
      end
      $display("accepted=%0d delivered=%0d errors=%0d", accepted, delivered, error_count);
      if (error_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- source/rv_decoder.sv
`include "rv_decoder_defs.svh"

module rv_decoder (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   in_valid,
   output logic                   in_ready,
   input  logic [`RV_XLEN-1:0]    in_instr,
   input  logic [`RV_XLEN-1:0]    in_pc,
   output logic [`RV_REG_W-1:0]   rf_rs1,
   output logic [`RV_REG_W-1:0]   rf_rs2,
   output logic                   out_valid,
   input  logic                   out_ready,
   output rv_decoder_pkg::rv_op_e out_op,
   output logic [`RV_REG_W-1:0]   out_rd,
   output logic [`RV_REG_W-1:0]   out_rs1,
   output logic [`RV_REG_W-1:0]   out_rs2,
   output logic [`RV_XLEN-1:0]    out_imm,
   output logic [`RV_XLEN-1:0]    out_pc,
   output logic                   out_is_load,
   output logic                   out_is_store,
   output logic                   out_is_branch,
   output logic                   out_writes_reg,
   output logic                   out_legal
);

   import rv_decoder_pkg::*;

   rv_op_e                op;
   rv_fmt_e               fmt;
   logic [`RV_XLEN-1:0]   imm;
   logic [`RV_REG_W-1:0]  rd;
   logic [`RV_REG_W-1:0]  rs1;
   logic [`RV_REG_W-1:0]  rs2;
   logic                  is_load;
   logic                  is_store;
   logic                  is_branch;
   logic                  writes_reg;
   logic                  legal;

   // lookahead for the register file, unregistered
   assign rf_rs1 = in_instr[19:15];
   assign rf_rs2 = in_instr[24:20];

   // zero fields the format does not carry
   assign rd  = (fmt inside {FMT_R, FMT_I, FMT_U, FMT_J}) ? in_instr[11:7] : '0;
   assign rs1 = (fmt inside {FMT_R, FMT_I, FMT_S, FMT_B}) ? in_instr[19:15] : '0;
   assign rs2 = (fmt inside {FMT_R, FMT_S, FMT_B}) ? in_instr[24:20] : '0;

   rv_op_decode u_op_decode (
      .instr      (in_instr),
      .op         (op),
      .fmt        (fmt),
      .is_load    (is_load),
      .is_store   (is_store),
      .is_branch  (is_branch),
      .writes_reg (writes_reg),
      .legal      (legal)
   );

   rv_imm_gen u_imm_gen (
      .instr (in_instr),
      .fmt   (fmt),
      .imm   (imm)
   );

   rv_decode_reg u_decode_reg (
      .clk            (clk),
      .rstn           (rstn),
      .in_valid       (in_valid),
      .in_ready       (in_ready),
      .op             (op),
      .rd             (rd),
      .rs1            (rs1),
      .rs2            (rs2),
      .imm            (imm),
      .pc             (in_pc),
      .is_load        (is_load),
      .is_store       (is_store),
      .is_branch      (is_branch),
      .writes_reg     (writes_reg),
      .legal          (legal),
      .out_valid      (out_valid),
      .out_ready      (out_ready),
      .out_op         (out_op),
      .out_rd         (out_rd),
      .out_rs1        (out_rs1),
      .out_rs2        (out_rs2),
      .out_imm        (out_imm),
      .out_pc         (out_pc),
      .out_is_load    (out_is_load),
      .out_is_store   (out_is_store),
      .out_is_branch  (out_is_branch),
      .out_writes_reg (out_writes_reg),
      .out_legal      (out_legal)
   );

endmodule

//--- source/rv_decode_reg.sv
`include "rv_decoder_defs.svh"

module rv_decode_reg (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   in_valid,
   output logic                   in_ready,
   input  rv_decoder_pkg::rv_op_e op,
   input  logic [`RV_REG_W-1:0]   rd,
   input  logic [`RV_REG_W-1:0]   rs1,
   input  logic [`RV_REG_W-1:0]   rs2,
   input  logic [`RV_XLEN-1:0]    imm,
   input  logic [`RV_XLEN-1:0]    pc,
   input  logic                   is_load,
   input  logic                   is_store,
   input  logic                   is_branch,
   input  logic                   writes_reg,
   input  logic                   legal,
   output logic                   out_valid,
   input  logic                   out_ready,
   output rv_decoder_pkg::rv_op_e out_op,
   output logic [`RV_REG_W-1:0]   out_rd,
   output logic [`RV_REG_W-1:0]   out_rs1,
   output logic [`RV_REG_W-1:0]   out_rs2,
   output logic [`RV_XLEN-1:0]    out_imm,
   output logic [`RV_XLEN-1:0]    out_pc,
   output logic                   out_is_load,
   output logic                   out_is_store,
   output logic                   out_is_branch,
   output logic                   out_writes_reg,
   output logic                   out_legal
);

   import rv_decoder_pkg::*;

   logic accept;

   // slot is free when empty or draining this cycle
   assign in_ready = !out_valid || out_ready;
   assign accept   = in_valid && in_ready;

   always_ff @(posedge clk) begin
      if (rstn) begin
         out_valid <= 1'b0;
      end else if (in_ready) begin
         out_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         out_op         <= op;
         out_rd         <= rd;
         out_rs1        <= rs1;
         out_rs2        <= rs2;
         out_imm        <= imm;
         out_pc         <= pc;
         out_is_load    <= is_load;
         out_is_store   <= is_store;
         out_is_branch  <= is_branch;
         out_writes_reg <= writes_reg;
         out_legal      <= legal;
      end
   end

   a_reset_empty: assert property (@(posedge clk) rstn |=> !out_valid)
      else $error("out_valid set after reset");

   // stalled record must not move
   a_hold: assert property (@(posedge clk) disable iff (rstn)
      out_valid && !out_ready |=> out_valid &&
         $stable({out_op, out_rd, out_rs1, out_rs2, out_imm, out_pc, out_is_load,
                  out_is_store, out_is_branch, out_writes_reg, out_legal}))
      else $error("record changed under back-pressure");

   a_legal_op: assert property (@(posedge clk) disable iff (rstn)
      out_valid && out_legal |-> out_op != OP_ILLEGAL)
      else $error("legal record carries no operation");

endmodule

//--- source/rv_imm_gen.sv
`include "rv_decoder_defs.svh"

module rv_imm_gen (
   input  logic [`RV_XLEN-1:0]     instr,
   input  rv_decoder_pkg::rv_fmt_e fmt,
   output logic [`RV_XLEN-1:0]     imm
);

   import rv_decoder_pkg::*;

   logic sign;

   assign sign = instr[31];

   always_comb begin
      case (fmt)
         FMT_I: begin
            imm = {{20{sign}}, instr[31:20]};
         end
         FMT_S: begin
            imm = {{20{sign}}, instr[31:25], instr[11:7]};
         end
         // branch offsets are halfword aligned
         FMT_B: begin
            imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
         end
         FMT_U: begin
            imm = {instr[31:12], 12'b0};
         end
         FMT_J: begin
            imm = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
         end
         // r type and unmatched words
         default: begin
            imm = '0;
         end
      endcase
   end

endmodule

//--- source/rv_op_decode.sv
`include "rv_decoder_defs.svh"

module rv_op_decode (
   input  logic [`RV_XLEN-1:0]     instr,
   output rv_decoder_pkg::rv_op_e  op,
   output rv_decoder_pkg::rv_fmt_e fmt,
   output logic                    is_load,
   output logic                    is_store,
   output logic                    is_branch,
   output logic                    writes_reg,
   output logic                    legal
);

   import rv_decoder_pkg::*;

   rv_opcode_e            opc;
   logic [2:0]            funct3;
   logic [6:0]            funct7;
   logic [`RV_REG_W-1:0]  rd;
   logic [`RV_REG_W-1:0]  rs1;

   assign opc    = rv_opcode_e'(instr[6:0]);
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];
   assign rd     = instr[11:7];
   assign rs1    = instr[19:15];

   always_comb begin
      op  = OP_ILLEGAL;
      fmt = FMT_NONE;
      case (opc)
         OPC_LUI: begin
            op  = OP_LUI;
            fmt = FMT_U;
         end
         OPC_AUIPC: begin
            op  = OP_AUIPC;
            fmt = FMT_U;
         end
         OPC_JAL: begin
            op  = OP_JAL;
            fmt = FMT_J;
         end
         OPC_JALR: begin
            fmt = FMT_I;
            if (funct3 == 3'b000) op = OP_JALR;
         end
         OPC_BRANCH: begin
            fmt = FMT_B;
            case (funct3)
               3'b000:  op = OP_BEQ;
               3'b001:  op = OP_BNE;
               3'b100:  op = OP_BLT;
               3'b101:  op = OP_BGE;
               3'b110:  op = OP_BLTU;
               3'b111:  op = OP_BGEU;
               default: op = OP_ILLEGAL;
            endcase
         end
         OPC_LOAD: begin
            fmt = FMT_I;
            case (funct3)
               3'b000:  op = OP_LB;
               3'b001:  op = OP_LH;
               3'b010:  op = OP_LW;
               3'b100:  op = OP_LBU;
               3'b101:  op = OP_LHU;
               default: op = OP_ILLEGAL;
            endcase
         end
         OPC_STORE: begin
            fmt = FMT_S;
            case (funct3)
               3'b000:  op = OP_SB;
               3'b001:  op = OP_SH;
               3'b010:  op = OP_SW;
               default: op = OP_ILLEGAL;
            endcase
         end
         OPC_OP_IMM: begin
            fmt = FMT_I;
            case (funct3)
               3'b000:  op = OP_ADDI;
               3'b010:  op = OP_SLTI;
               3'b011:  op = OP_SLTIU;
               3'b100:  op = OP_XORI;
               3'b110:  op = OP_ORI;
               3'b111:  op = OP_ANDI;
               // shift amount sits in rs2, funct7 picks the kind
               3'b001:  op = (funct7 == `RV_F7_BASE) ? OP_SLLI : OP_ILLEGAL;
               default: begin
                  if (funct7 == `RV_F7_BASE) op = OP_SRLI;
                  else if (funct7 == `RV_F7_ALT) op = OP_SRAI;
               end
            endcase
         end
         OPC_OP: begin
            fmt = FMT_R;
            if (funct7 == `RV_F7_BASE) begin
               case (funct3)
                  3'b000:  op = OP_ADD;
                  3'b001:  op = OP_SLL;
                  3'b010:  op = OP_SLT;
                  3'b011:  op = OP_SLTU;
                  3'b100:  op = OP_XOR;
                  3'b101:  op = OP_SRL;
                  3'b110:  op = OP_OR;
                  default: op = OP_AND;
               endcase
            end else if (funct7 == `RV_F7_ALT) begin
               if (funct3 == 3'b000) op = OP_SUB;
               else if (funct3 == 3'b101) op = OP_SRA;
            end else if (funct7 == `RV_F7_MULDIV) begin
               case (funct3)
                  3'b000:  op = OP_MUL;
                  3'b001:  op = OP_MULH;
                  3'b010:  op = OP_MULHSU;
                  3'b011:  op = OP_MULHU;
                  3'b100:  op = OP_DIV;
                  3'b101:  op = OP_DIVU;
                  3'b110:  op = OP_REM;
                  default: op = OP_REMU;
               endcase
            end
         end
         OPC_MISC_MEM: begin
            fmt = FMT_I;
            if (rd == '0 && rs1 == '0) begin
               if (funct3 == 3'b000) op = OP_FENCE;
               else if (funct3 == 3'b001) op = OP_FENCE_I;
            end
         end
         OPC_SYSTEM: begin
            fmt = FMT_I;
            // only ecall and ebreak remain here
            if (funct3 == 3'b000 && rd == '0 && rs1 == '0) begin
               if (instr[31:20] == `RV_SYS_ECALL) op = OP_ECALL;
               else if (instr[31:20] == `RV_SYS_EBREAK) op = OP_EBREAK;
            end
         end
         default: op = OP_ILLEGAL;
      endcase
      if (op == OP_ILLEGAL) fmt = FMT_NONE;
   end

   assign legal     = (op != OP_ILLEGAL);
   assign is_load   = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
   assign is_store  = op inside {OP_SB, OP_SH, OP_SW};
   assign is_branch = op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};

   // no destination for these
   assign writes_reg = legal && !(is_branch || is_store ||
                                  (op inside {OP_FENCE, OP_FENCE_I, OP_ECALL, OP_EBREAK}));

endmodule

//--- source/rv_decoder_pkg.sv
package rv_decoder_pkg;

   // instruction formats
   typedef enum logic [2:0] {
      FMT_R,
      FMT_I,
      FMT_S,
      FMT_B,
      FMT_U,
      FMT_J,
      FMT_NONE
   } rv_fmt_e;

   // major opcodes, bits 6:0 of the word
   typedef enum logic [6:0] {
      OPC_LUI      = 7'b0110111,
      OPC_AUIPC    = 7'b0010111,
      OPC_JAL      = 7'b1101111,
      OPC_JALR     = 7'b1100111,
      OPC_BRANCH   = 7'b1100011,
      OPC_LOAD     = 7'b0000011,
      OPC_STORE    = 7'b0100011,
      OPC_OP_IMM   = 7'b0010011,
      OPC_OP       = 7'b0110011,
      OPC_MISC_MEM = 7'b0001111,
      OPC_SYSTEM   = 7'b1110011
   } rv_opcode_e;

   // decoded operation, zero means no match
   typedef enum logic [5:0] {
      OP_ILLEGAL = 6'd0,
      // upper immediate and jumps
      OP_LUI, OP_AUIPC,
      OP_JAL, OP_JALR,
      // conditional branches
      OP_BEQ, OP_BNE, OP_BLT,
      OP_BGE, OP_BLTU, OP_BGEU,
      // loads and stores
      OP_LB, OP_LH, OP_LW,
      OP_LBU, OP_LHU,
      OP_SB, OP_SH, OP_SW,
      // register-immediate
      OP_ADDI, OP_SLTI, OP_SLTIU,
      OP_XORI, OP_ORI, OP_ANDI,
      OP_SLLI, OP_SRLI, OP_SRAI,
      // register-register
      OP_ADD, OP_SUB, OP_SLL,
      OP_SLT, OP_SLTU, OP_XOR,
      OP_SRL, OP_SRA, OP_OR,
      OP_AND,
      // ordering and environment
      OP_FENCE, OP_FENCE_I,
      OP_ECALL, OP_EBREAK,
      // rv32m
      OP_MUL, OP_MULH, OP_MULHSU,
      OP_MULHU, OP_DIV, OP_DIVU,
      OP_REM, OP_REMU
   } rv_op_e;

endpackage

//--- source/rv_decoder_defs.svh
`ifndef RV_DECODER_DEFS_SVH
`define RV_DECODER_DEFS_SVH

// data and pc width
`define RV_XLEN 32

// register index width
`define RV_REG_W 5

// funct7 values seen in legal RV32IM encodings
`define RV_F7_BASE 7'b0000000

// sub, sra, srai
`define RV_F7_ALT 7'b0100000

// M extension
`define RV_F7_MULDIV 7'b0000001

// fixed upper fields of the system instructions
`define RV_SYS_ECALL 12'h000
`define RV_SYS_EBREAK 12'h001

`endif
